//--- common/bmw_pkg.sv
// BMW-256 compression step: shared widths, types and word primitives.
// Words are 32 bits and word 0 sits in the low bits of every block.
// All arithmetic wraps modulo 2^32, as the hash defines it.
package bmw_pkg;

	localparam int WORD_W         = 32;
	localparam int NUM_WORDS      = 16;
	localparam int NUM_Q          = 32;
	// first expansion word computed after the pipeline register
	localparam int SPLIT_IDX      = 24;
	// expansion words that use the s-function form
	localparam int EXPAND1_ROUNDS = 2;
	localparam logic [WORD_W-1:0] K_STEP = 32'h05555555;

	typedef logic [WORD_W-1:0] word_t;
	typedef word_t [NUM_WORDS-1:0] block_t;
	typedef word_t [NUM_WORDS-1:0] qlow_t;

	// registered state between the two stages
	typedef struct packed {
		logic                                valid;
		qlow_t                               q0_15;
		word_t [SPLIT_IDX-NUM_WORDS-1:0]     q16_23;
		block_t                              msg;
		block_t                              chain;
	} stage1_t;

	// ----------------------------------------
	// word primitives
	// ----------------------------------------

	// n in 1..31
	function automatic word_t rotl(input word_t x, input int n);
		return (x << n) | (x >> (WORD_W - n));
	endfunction

	function automatic word_t s0(input word_t x);
		return (x >> 1) ^ (x << 3) ^ rotl(x, 4) ^ rotl(x, 19);
	endfunction

	function automatic word_t s1(input word_t x);
		return (x >> 1) ^ (x << 2) ^ rotl(x, 8) ^ rotl(x, 23);
	endfunction

	function automatic word_t s2(input word_t x);
		return (x >> 2) ^ (x << 1) ^ rotl(x, 12) ^ rotl(x, 25);
	endfunction

	function automatic word_t s3(input word_t x);
		return (x >> 2) ^ (x << 2) ^ rotl(x, 15) ^ rotl(x, 29);
	endfunction

	function automatic word_t s4(input word_t x);
		return (x >> 1) ^ x;
	endfunction

	function automatic word_t s5(input word_t x);
		return (x >> 2) ^ x;
	endfunction

	function automatic word_t r1(input word_t x);
		return rotl(x, 3);
	endfunction

	function automatic word_t r2(input word_t x);
		return rotl(x, 7);
	endfunction

	function automatic word_t r3(input word_t x);
		return rotl(x, 13);
	endfunction

	function automatic word_t r4(input word_t x);
		return rotl(x, 16);
	endfunction

	function automatic word_t r5(input word_t x);
		return rotl(x, 19);
	endfunction

	function automatic word_t r6(input word_t x);
		return rotl(x, 23);
	endfunction

	function automatic word_t r7(input word_t x);
		return rotl(x, 27);
	endfunction

	// message term of expansion word idx (16..31)
	function automatic word_t add_elt(input int idx, input block_t m, input block_t h);
		int    a;
		int    b;
		int    c;
		word_t k_term;
		a = (idx - 16) % NUM_WORDS;
		b = (idx - 13) % NUM_WORDS;
		c = (idx - 6) % NUM_WORDS;
		k_term = word_t'(idx) * K_STEP;
		return (k_term + rotl(m[a], a + 1) + rotl(m[b], b + 1) - rotl(m[c], c + 1))
			^ h[(idx - 9) % NUM_WORDS];
	endfunction

endpackage

//--- hw/bmw_round/bmw_bijective.sv
// f0 of BMW-256: bijective transform of message xor chaining value.
// Purely combinational.
`timescale 1ns/1ps

module bmw_bijective import bmw_pkg::*; (
	input  block_t msg,
	input  block_t chain,
	output qlow_t  q
);

	block_t t;
	word_t [NUM_WORDS-1:0] w;

	assign t = msg ^ chain;

	// ----------------------------------------
	// fixed five-term signed sums
	// ----------------------------------------
	assign w[0]  = t[5]  - t[7]  + t[10] + t[13] + t[14];
	assign w[1]  = t[6]  - t[8]  + t[11] + t[14] - t[15];
	assign w[2]  = t[0]  + t[7]  + t[9]  - t[12] + t[15];
	assign w[3]  = t[0]  - t[1]  + t[8]  - t[10] + t[13];
	assign w[4]  = t[1]  + t[2]  + t[9]  - t[11] - t[14];
	assign w[5]  = t[3]  - t[2]  + t[10] - t[12] + t[15];
	assign w[6]  = t[4]  - t[0]  - t[3]  - t[11] + t[13];
	assign w[7]  = t[1]  - t[4]  - t[5]  - t[12] - t[14];
	assign w[8]  = t[2]  - t[5]  - t[6]  + t[13] - t[15];
	assign w[9]  = t[0]  - t[3]  + t[6]  - t[7]  + t[14];
	assign w[10] = t[8]  - t[1]  - t[4]  - t[7]  + t[15];
	assign w[11] = t[8]  - t[0]  - t[2]  - t[5]  + t[9];
	assign w[12] = t[1]  + t[3]  - t[6]  - t[9]  + t[10];
	assign w[13] = t[2]  + t[4]  + t[7]  + t[10] + t[11];
	assign w[14] = t[3]  - t[5]  + t[8]  - t[11] - t[12];
	assign w[15] = t[12] - t[4]  - t[6]  - t[9]  + t[13];

	// s0..s4 in rotation, then the next chaining word
	always_comb
	begin
		for (int i = 0; i < NUM_WORDS; i++)
		begin
			case (i % 5)
				0:
					q[i] = s0(w[i]);
				1:
					q[i] = s1(w[i]);
				2:
					q[i] = s2(w[i]);
				3:
					q[i] = s3(w[i]);
				default:
					q[i] = s4(w[i]);
			endcase
			q[i] = q[i] + chain[(i + 1) % NUM_WORDS];
		end
	end

endmodule

//--- hw/bmw_round/bmw_expand_word.sv
// One f1 expansion word Q[IDX] of BMW-256, IDX in 16..31.
// prev carries Q[IDX-16]..Q[IDX-1] with the oldest word at index 0.
// The first EXPAND1_ROUNDS words use the s-function form.
`timescale 1ns/1ps

module bmw_expand_word import bmw_pkg::*; #(
	parameter int IDX = 16
) (
	input  qlow_t  prev,
	input  block_t msg,
	input  block_t chain,
	output word_t  q
);

	word_t acc;

	if (IDX < NUM_WORDS || IDX >= NUM_Q)
	begin : g_bad_idx
		$error("bmw_expand_word: IDX %0d out of range", IDX);
	end

	always_comb
	begin
		acc = add_elt(IDX, msg, chain);
		if (IDX < NUM_WORDS + EXPAND1_ROUNDS)
		begin
			// s1, s2, s3, s0 over all sixteen previous words
			for (int k = 0; k < NUM_WORDS; k++)
			begin
				case (k % 4)
					0:
						acc = acc + s1(prev[k]);
					1:
						acc = acc + s2(prev[k]);
					2:
						acc = acc + s3(prev[k]);
					default:
						acc = acc + s0(prev[k]);
				endcase
			end
		end
		else
		begin
			// plain and r1..r7 rotated words alternate
			for (int k = 0; k < NUM_WORDS - 2; k++)
			begin
				case (k)
					1:
						acc = acc + r1(prev[k]);
					3:
						acc = acc + r2(prev[k]);
					5:
						acc = acc + r3(prev[k]);
					7:
						acc = acc + r4(prev[k]);
					9:
						acc = acc + r5(prev[k]);
					11:
						acc = acc + r6(prev[k]);
					13:
						acc = acc + r7(prev[k]);
					default:
						acc = acc + prev[k];
				endcase
			end
			acc = acc + s4(prev[NUM_WORDS-2]) + s5(prev[NUM_WORDS-1]);
		end
	end

	assign q = acc;

endmodule

//--- hw/bmw_round/bmw_fold.sv
// f2 of BMW-256: folds Q0..Q31 and the message into the new chaining value.
// Combinational. Words 8..15 depend on words 0..7.
`timescale 1ns/1ps

module bmw_fold import bmw_pkg::*; (
	input  qlow_t  qa,
	input  qlow_t  qb,
	input  block_t msg,
	output block_t digest_next
);

	localparam int HALF = NUM_WORDS / 2;

	word_t                xl;
	word_t                xh;
	word_t [HALF-1:0]     hi_term;
	word_t [HALF-1:0]     xl_term;

	// ----------------------------------------
	// xor folds of the expansion words
	// ----------------------------------------
	always_comb
	begin
		xl = '0;
		for (int i = 0; i < HALF; i++)
			xl = xl ^ qb[i];
		xh = xl;
		for (int i = HALF; i < NUM_WORDS; i++)
			xh = xh ^ qb[i];
	end

	// shift pairs for words 0..7
	assign hi_term[0] = (xh << 5)  ^ (qb[0] >> 5);
	assign hi_term[1] = (xh >> 7)  ^ (qb[1] << 8);
	assign hi_term[2] = (xh >> 5)  ^ (qb[2] << 5);
	assign hi_term[3] = (xh >> 1)  ^ (qb[3] << 5);
	assign hi_term[4] = (xh >> 3)  ^ qb[4];
	assign hi_term[5] = (xh << 6)  ^ (qb[5] >> 6);
	assign hi_term[6] = (xh >> 4)  ^ (qb[6] << 6);
	assign hi_term[7] = (xh >> 11) ^ (qb[7] << 2);

	// xl shifts for words 8..15
	assign xl_term[0] = xl << 8;
	assign xl_term[1] = xl >> 6;
	assign xl_term[2] = xl << 6;
	assign xl_term[3] = xl << 4;
	assign xl_term[4] = xl >> 3;
	assign xl_term[5] = xl >> 4;
	assign xl_term[6] = xl >> 7;
	assign xl_term[7] = xl >> 2;

	always_comb
	begin
		for (int i = 0; i < HALF; i++)
			digest_next[i] = (hi_term[i] ^ msg[i]) + (xl ^ qb[HALF+i] ^ qa[i]);
		// upper half rotates an earlier output word by i+1
		for (int i = HALF; i < NUM_WORDS; i++)
		begin
			digest_next[i] = rotl(digest_next[(i + 4) % HALF], i + 1)
				+ (xh ^ qb[i] ^ msg[i])
				+ (xl_term[i-HALF] ^ qb[(i - 1) % HALF] ^ qa[i]);
		end
	end

endmodule

//--- hw/bmw_round/bmw_stage1.sv
// First pipeline stage: f0 and expansion words 16..SPLIT_IDX-1.
// msg and chain are sampled only on an edge where start is high.
// s1.valid follows start at every edge.
`timescale 1ns/1ps

module bmw_stage1 import bmw_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  block_t  msg,
	input  block_t  chain,
	output stage1_t s1
);

	localparam int N_EXP = SPLIT_IDX - NUM_WORDS;

	word_t [SPLIT_IDX-1:0] q_all;
	qlow_t                 q_low;

	logic                  valid_q;
	qlow_t                 q0_15_q;
	word_t [N_EXP-1:0]     q16_23_q;
	block_t                msg_q;
	block_t                chain_q;

	bmw_bijective bmw_bijective_i (
		.msg   (msg),
		.chain (chain),
		.q     (q_low)
	);

	assign q_all[NUM_WORDS-1:0] = q_low;

	// ----------------------------------------
	// expansion chain, each word sees the 16 before it
	// ----------------------------------------
	for (genvar j = NUM_WORDS; j < SPLIT_IDX; j++)
	begin : g_exp
		bmw_expand_word #(.IDX(j)) bmw_expand_word_i (
			.prev  (q_all[j-1 -: NUM_WORDS]),
			.msg   (msg),
			.chain (chain),
			.q     (q_all[j])
		);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= start;
	end

	// payload
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			q0_15_q  <= q_low;
			q16_23_q <= q_all[SPLIT_IDX-1:NUM_WORDS];
			msg_q    <= msg;
			chain_q  <= chain;
		end
	end

	assign s1 = '{valid: valid_q, q0_15: q0_15_q, q16_23: q16_23_q, msg: msg_q, chain: chain_q};

	a_start_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(start))
		else $error("start is unknown");

endmodule

//--- hw/bmw_round/bmw_stage2.sv
// Second pipeline stage: expansion words SPLIT_IDX..31, f2, output register.
// done is a one-cycle copy of s1.valid.
// digest loads only with s1.valid and holds between done pulses.
`timescale 1ns/1ps

module bmw_stage2 import bmw_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  stage1_t s1,
	output logic    done,
	output block_t  digest
);

	word_t [NUM_Q-1:0] q_all;
	block_t            digest_next;

	// registered words from stage 1
	assign q_all[NUM_WORDS-1:0]         = s1.q0_15;
	assign q_all[SPLIT_IDX-1:NUM_WORDS] = s1.q16_23;

	// ----------------------------------------
	// rest of the expansion
	// ----------------------------------------
	for (genvar j = SPLIT_IDX; j < NUM_Q; j++)
	begin : g_exp
		bmw_expand_word #(.IDX(j)) bmw_expand_word_i (
			.prev  (q_all[j-1 -: NUM_WORDS]),
			.msg   (s1.msg),
			.chain (s1.chain),
			.q     (q_all[j])
		);
	end

	bmw_fold bmw_fold_i (
		.qa          (q_all[NUM_WORDS-1:0]),
		.qb          (q_all[NUM_Q-1:NUM_WORDS]),
		.msg         (s1.msg),
		.digest_next (digest_next)
	);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			done   <= 1'b0;
			digest <= '0;
		end
		else
		begin
			done <= s1.valid;
			if (s1.valid)
				digest <= digest_next;
		end
	end

	// a finished block leaves no unknown bits in digest
	a_digest_known: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !$isunknown(digest))
		else $error("digest unknown while done is high");

endmodule

//--- hw/bmw_round/bmw_round_top.sv
// BMW-256 compression step, two register stages.
// A block may start on every cycle; done follows start by two edges.
// No back-pressure: digest must be taken while done is high.
`timescale 1ns/1ps

module bmw_round_top import bmw_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	input  block_t msg,
	input  block_t chain,
	output logic   done,
	output block_t digest
);

	stage1_t s1;

	// f0 and first half of f1
	bmw_stage1 bmw_stage1_i (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.msg   (msg),
		.chain (chain),
		.s1    (s1)
	);

	// second half of f1, f2 and output register
	bmw_stage2 bmw_stage2_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.s1     (s1),
		.done   (done),
		.digest (digest)
	);

endmodule

//--- sim/bmw_checker.sv
// Watches the BMW-256 round ports and checks every digest against a model.
// Samples on the falling edge, where DUT outputs and TB inputs are settled.
// Expects done exactly two samples after start, with no back-pressure.
`timescale 1ns/1ps

module bmw_checker import bmw_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	input  block_t msg,
	input  block_t chain,
	input  logic   done,
	input  block_t digest,
	output int     value_errors,
	output int     protocol_errors,
	output int     pending
);

	int     n_value    = 0;
	int     n_protocol = 0;
	int     n_pending  = 0;
	block_t exp_q[$];
	block_t last_digest = '0;
	logic   start_d1    = 1'b0;
	logic   start_d2    = 1'b0;

	assign value_errors    = n_value;
	assign protocol_errors = n_protocol;
	assign pending         = n_pending;

	// ----------------------------------------
	// model of one compression step
	// ----------------------------------------
	function automatic block_t bmw_compress_ref(input block_t m, input block_t h);
		word_t  t [NUM_WORDS];
		word_t  w [NUM_WORDS];
		word_t  q [NUM_Q];
		word_t  acc;
		word_t  xl;
		word_t  xh;
		block_t r;
		for (int i = 0; i < NUM_WORDS; i++)
			t[i] = m[i] ^ h[i];
		// f0 sums
		w[0]  = t[5] - t[7] + t[10] + t[13] + t[14];
		w[1]  = t[6] - t[8] + t[11] + t[14] - t[15];
		w[2]  = t[0] + t[7] + t[9] - t[12] + t[15];
		w[3]  = t[0] - t[1] + t[8] - t[10] + t[13];
		w[4]  = t[1] + t[2] + t[9] - t[11] - t[14];
		w[5]  = t[3] - t[2] + t[10] - t[12] + t[15];
		w[6]  = t[4] - t[0] - t[3] - t[11] + t[13];
		w[7]  = t[1] - t[4] - t[5] - t[12] - t[14];
		w[8]  = t[2] - t[5] - t[6] + t[13] - t[15];
		w[9]  = t[0] - t[3] + t[6] - t[7] + t[14];
		w[10] = t[8] - t[1] - t[4] - t[7] + t[15];
		w[11] = t[8] - t[0] - t[2] - t[5] + t[9];
		w[12] = t[1] + t[3] - t[6] - t[9] + t[10];
		w[13] = t[2] + t[4] + t[7] + t[10] + t[11];
		w[14] = t[3] - t[5] + t[8] - t[11] - t[12];
		w[15] = t[12] - t[4] - t[6] - t[9] + t[13];
		for (int i = 0; i < NUM_WORDS; i++)
		begin
			case (i % 5)
				0: acc = s0(w[i]);
				1: acc = s1(w[i]);
				2: acc = s2(w[i]);
				3: acc = s3(w[i]);
				default: acc = s4(w[i]);
			endcase
			q[i] = acc + h[(i + 1) % NUM_WORDS];
		end
		// f1, expand1 words then expand2 words
		for (int j = NUM_WORDS; j < NUM_Q; j++)
		begin
			acc = add_elt(j, m, h);
			if (j < NUM_WORDS + EXPAND1_ROUNDS)
			begin
				for (int k = 0; k < NUM_WORDS; k += 4)
					acc = acc + s1(q[j-16+k]) + s2(q[j-15+k]) + s3(q[j-14+k]) + s0(q[j-13+k]);
			end
			else
			begin
				acc = acc + q[j-16] + r1(q[j-15]) + q[j-14] + r2(q[j-13]);
				acc = acc + q[j-12] + r3(q[j-11]) + q[j-10] + r4(q[j-9]);
				acc = acc + q[j-8] + r5(q[j-7]) + q[j-6] + r6(q[j-5]);
				acc = acc + q[j-4] + r7(q[j-3]) + s4(q[j-2]) + s5(q[j-1]);
			end
			q[j] = acc;
		end
		// f2
		xl = '0;
		for (int i = 16; i < 24; i++)
			xl = xl ^ q[i];
		xh = xl;
		for (int i = 24; i < NUM_Q; i++)
			xh = xh ^ q[i];
		r[0]  = ((xh << 5) ^ (q[16] >> 5) ^ m[0]) + (xl ^ q[24] ^ q[0]);
		r[1]  = ((xh >> 7) ^ (q[17] << 8) ^ m[1]) + (xl ^ q[25] ^ q[1]);
		r[2]  = ((xh >> 5) ^ (q[18] << 5) ^ m[2]) + (xl ^ q[26] ^ q[2]);
		r[3]  = ((xh >> 1) ^ (q[19] << 5) ^ m[3]) + (xl ^ q[27] ^ q[3]);
		r[4]  = ((xh >> 3) ^ q[20] ^ m[4]) + (xl ^ q[28] ^ q[4]);
		r[5]  = ((xh << 6) ^ (q[21] >> 6) ^ m[5]) + (xl ^ q[29] ^ q[5]);
		r[6]  = ((xh >> 4) ^ (q[22] << 6) ^ m[6]) + (xl ^ q[30] ^ q[6]);
		r[7]  = ((xh >> 11) ^ (q[23] << 2) ^ m[7]) + (xl ^ q[31] ^ q[7]);
		r[8]  = rotl(r[4], 9) + (xh ^ q[24] ^ m[8]) + ((xl << 8) ^ q[23] ^ q[8]);
		r[9]  = rotl(r[5], 10) + (xh ^ q[25] ^ m[9]) + ((xl >> 6) ^ q[16] ^ q[9]);
		r[10] = rotl(r[6], 11) + (xh ^ q[26] ^ m[10]) + ((xl << 6) ^ q[17] ^ q[10]);
		r[11] = rotl(r[7], 12) + (xh ^ q[27] ^ m[11]) + ((xl << 4) ^ q[18] ^ q[11]);
		r[12] = rotl(r[0], 13) + (xh ^ q[28] ^ m[12]) + ((xl >> 3) ^ q[19] ^ q[12]);
		r[13] = rotl(r[1], 14) + (xh ^ q[29] ^ m[13]) + ((xl >> 4) ^ q[20] ^ q[13]);
		r[14] = rotl(r[2], 15) + (xh ^ q[30] ^ m[14]) + ((xl >> 7) ^ q[21] ^ q[14]);
		r[15] = rotl(r[3], 16) + (xh ^ q[31] ^ m[15]) + ((xl >> 2) ^ q[22] ^ q[15]);
		return r;
	endfunction

	// ----------------------------------------
	// compare process
	// ----------------------------------------
	always @(negedge clk)
	begin : watch
		block_t exp_d;
		if (!rst_n)
		begin
			if (done !== 1'b0 || digest !== '0)
			begin
				$display("CHECK FAILED at %0t: done or digest not cleared in reset", $time);
				n_value++;
			end
			start_d1 = 1'b0;
			start_d2 = 1'b0;
		end
		else
		begin
			if (done !== start_d2)
			begin
				$display("done at %0t does not follow a start two cycles earlier", $time);
				n_protocol++;
			end
			if (done === 1'b1)
			begin
				if (exp_q.size() == 0)
				begin
					$display("done at %0t arrived with no block in flight", $time);
					n_protocol++;
				end
				else
				begin
					exp_d = exp_q.pop_front();
					for (int i = 0; i < NUM_WORDS; i++)
						if (digest[i] !== exp_d[i])
						begin
							$display("CHECK FAILED at %0t: digest word %0d got %h expected %h",
								$time, i, digest[i], exp_d[i]);
							n_value++;
						end
				end
				last_digest = digest;
			end
			else if (digest !== last_digest)
			begin
				$display("CHECK FAILED at %0t: digest changed without done", $time);
				n_value++;
			end
			// pop before push, the block just started is not due yet
			if (start === 1'b1)
				exp_q.push_back(bmw_compress_ref(msg, chain));
			start_d2 = start_d1;
			start_d1 = start;
		end
		n_pending = exp_q.size();
	end

endmodule

//--- sim/tb_bmw_round.sv
// Testbench for the two-stage BMW-256 compression step.
// Inputs change on the rising edge, bmw_checker does all comparing.
// Random data comes from one fixed seed, so every run is the same.
`timescale 1ns/1ps

module tb_bmw_round import bmw_pkg::*; ();

	logic   clk = 1'b0;
	logic   rst_n;
	logic   start;
	block_t msg;
	block_t chain;
	logic   done;
	block_t digest;

	integer seed = 32'he2b3;
	int     value_errors;
	int     protocol_errors;
	int     pending;
	int     timeouts = 0;

	initial
	begin
		forever #5 clk = ~clk;
	end

	bmw_round_top bmw_round_top_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.msg    (msg),
		.chain  (chain),
		.done   (done),
		.digest (digest)
	);

	bmw_checker bmw_checker_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.start           (start),
		.msg             (msg),
		.chain           (chain),
		.done            (done),
		.digest          (digest),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors),
		.pending         (pending)
	);

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	task automatic rand_block(output block_t b);
		for (int i = 0; i < NUM_WORDS; i++)
			b[i] = $random(seed);
	endtask

	task automatic drive_start(input block_t m, input block_t c);
		@(posedge clk);
		start <= 1'b1;
		msg   <= m;
		chain <= c;
	endtask

	// start low, data keeps moving
	task automatic drive_idle(input int cycles);
		block_t m;
		block_t c;
		for (int n = 0; n < cycles; n++)
		begin
			rand_block(m);
			rand_block(c);
			@(posedge clk);
			start <= 1'b0;
			msg   <= m;
			chain <= c;
		end
	endtask

	task automatic wait_for_done(input int max_cycles);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < max_cycles)
		begin
			@(negedge clk);
			seen = (done === 1'b1);
			n++;
		end
		if (!seen)
		begin
			$display("no done within %0d cycles at %0t", max_cycles, $time);
			timeouts++;
		end
	endtask

	task automatic wait_drained(input int max_cycles);
		int n;
		n = 0;
		while (pending != 0 && n < max_cycles)
		begin
			@(negedge clk);
			n++;
		end
		if (pending != 0)
		begin
			$display("%0d blocks still in flight after %0d cycles", pending, max_cycles);
			timeouts++;
		end
	endtask

	initial
	begin
		block_t m;
		block_t c;
		int     gap;
		rst_n = 1'b0;
		start = 1'b0;
		msg   = '0;
		chain = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		// outputs must stay quiet after reset
		drive_idle(3);

		// all-zero block
		drive_start('0, '0);
		drive_idle(1);
		wait_for_done(8);

		// back-to-back blocks, two in flight
		for (int b = 0; b < 20; b++)
		begin
			rand_block(m);
			rand_block(c);
			drive_start(m, c);
		end
		drive_idle(1);
		wait_drained(20);

		// random gaps with moving data
		for (int b = 0; b < 15; b++)
		begin
			rand_block(m);
			rand_block(c);
			drive_start(m, c);
			gap = $unsigned($random(seed)) % 5;
			drive_idle(gap);
		end
		drive_idle(1);
		wait_drained(20);
		// any late done shows up here
		drive_idle(6);

		$display("errors: %0d value, %0d protocol, %0d timeouts",
			value_errors, protocol_errors, timeouts);
		if (value_errors == 0 && protocol_errors == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- build.f
common/bmw_pkg.sv
hw/bmw_round/bmw_bijective.sv
hw/bmw_round/bmw_expand_word.sv
hw/bmw_round/bmw_fold.sv
hw/bmw_round/bmw_stage1.sv
hw/bmw_round/bmw_stage2.sv
hw/bmw_round/bmw_round_top.sv
sim/bmw_checker.sv
sim/tb_bmw_round.sv

//--- run_sim.sh
#!/bin/bash
# Builds and runs the BMW-256 round testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module tb_bmw_round \
	--Mdir obj_dir \
	-o sim_bmw_round

./obj_dir/sim_bmw_round 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished without failure"
